//--- src/cosmic_pkg.sv
`default_nettype none

package cosmic_pkg;

	// Game numbers as delivered by the core_mod field
	localparam int GAME_W = 7;

	localparam logic [GAME_W-1:0] GAME_PANIC     = 7'd1;
	localparam logic [GAME_W-1:0] GAME_MAGSPOT   = 7'd2;
	localparam logic [GAME_W-1:0] GAME_ALIEN     = 7'd3;
	localparam logic [GAME_W-1:0] GAME_DEVILZONE = 7'd4;
	localparam logic [GAME_W-1:0] GAME_NML       = 7'd5;

	localparam int PORT_W = 8;

	// Download stream and program ROM widths
	localparam int DL_ADDR_W  = 25;
	localparam int DL_DATA_W  = 8;
	localparam int ROM_ADDR_W = 16;

	// Start of the sample table inside the download image
	localparam logic [DL_ADDR_W-1:0] TABLE_OFS_NML       = 25'd30720;
	localparam logic [DL_ADDR_W-1:0] TABLE_OFS_DEVILZONE = 25'd30752;
	localparam logic [DL_ADDR_W-1:0] TABLE_OFS_ALIEN     = 25'd29696;
	localparam logic [DL_ADDR_W-1:0] TABLE_OFS_DEFAULT   = 25'd26656;

	// Wave data follows straight after the table
	localparam logic [DL_ADDR_W-1:0] TABLE_LEN_NML     = 25'd192;
	localparam logic [DL_ADDR_W-1:0] TABLE_LEN_DEFAULT = 25'd128;

	// CPU enable period in clk_sys cycles, 2.7 MHz and 1.8 MHz
	localparam int DIV_FAST = 4;
	localparam int DIV_SLOW = 6;

	// One player byte, active low, seen through either cabinet layout
	typedef union packed {
		struct packed {
			logic       fire_b;
			logic [1:0] unused;
			logic       up;
			logic       down;
			logic       left;
			logic       right;
			logic       fire_a;
		} panic;
		struct packed {
			logic [4:0] unused;
			logic       left;
			logic       right;
			logic       fire_a;
		} alien;
	} player_port_u;

endpackage

`default_nettype wire

//--- src/dl_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-wide ROM download stream, no back-pressure
interface dl_bus_if;

	logic                             download;
	logic [7:0]                       index;
	logic                             wr;
	logic [cosmic_pkg::DL_ADDR_W-1:0] addr;
	logic [cosmic_pkg::DL_DATA_W-1:0] data;

	modport source (output download, index, wr, addr, data);
	modport sink   (input download, index, wr, addr, data);

endinterface

`default_nettype wire

//--- src/clock_enable_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen (
	input  wire logic                          clk_sys,
	input  wire logic                          reset_i,
	input  wire logic [cosmic_pkg::GAME_W-1:0] game_i,
	output logic                               pix_ena_o,
	output logic                               cpu_ena_o
);

	// The 7474 and 74161 dividers of the original board
	logic [1:0] pix_div;
	logic [2:0] cpu_div;
	logic       fast_game;

	// MagSpot and DevilZone run the CPU at 2.7 MHz
	assign fast_game = (game_i == cosmic_pkg::GAME_MAGSPOT) ||
		(game_i == cosmic_pkg::GAME_DEVILZONE);

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			pix_div   <= '0;
			cpu_div   <= '0;
			pix_ena_o <= 1'b0;
			cpu_ena_o <= 1'b0;
		end else begin
			pix_div <= pix_div + 2'd1;
			if (cpu_div == 3'(cosmic_pkg::DIV_SLOW - 1))
				cpu_div <= '0;
			else
				cpu_div <= cpu_div + 3'd1;

			pix_ena_o <= pix_div[0];
			if (fast_game)
				cpu_ena_o <= (pix_div == 2'(cosmic_pkg::DIV_FAST - 1));
			else
				cpu_ena_o <= (cpu_div == 3'(cosmic_pkg::DIV_SLOW - 1));
		end
	end

endmodule

`default_nettype wire

//--- src/reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
	input  wire logic clk_sys,
	input  wire logic reset_i,
	dl_bus_if.sink    dl,
	output logic      core_reset_o
);

	logic download_d;
	logic rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			download_d   <= 1'b0;
			rom_loaded   <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			download_d <= dl.download;

			// ROM counts as loaded once a download has ended
			if (download_d && !dl.download)
				rom_loaded <= 1'b1;

			// Hold the core while loading, through the edge detect, or with no ROM yet
			core_reset_o <= dl.download | download_d | ~rom_loaded;
		end
	end

endmodule

`default_nettype wire

//--- src/input_mapper.sv
`timescale 1ns/1ps
`default_nettype none

// Player bits: [5] fire B, [4] fire A, [3] up, [2] down, [1] left, [0] right
module input_mapper (
	input  wire logic [cosmic_pkg::GAME_W-1:0] game_i,
	input  wire logic [15:0]                   dip_i,
	input  wire logic [5:0]                    p1_i,
	input  wire logic [5:0]                    p2_i,
	input  wire logic                          coin_i,
	input  wire logic                          start1_i,
	input  wire logic                          start2_i,
	input  wire logic                          vblank_i,
	input  wire logic [8:0]                    vcount_i,
	output logic [cosmic_pkg::PORT_W-1:0]      in0_o,
	output logic [cosmic_pkg::PORT_W-1:0]      in1_o,
	output logic [cosmic_pkg::PORT_W-1:0]      in2_o,
	output logic [cosmic_pkg::PORT_W-1:0]      dipsw1_o
);

	function automatic cosmic_pkg::player_port_u panic_port(input logic [5:0] p);
		cosmic_pkg::player_port_u u;
		u.panic.fire_b = ~p[5];
		u.panic.unused = 2'b11;
		u.panic.up     = ~p[3];
		u.panic.down   = ~p[2];
		u.panic.left   = ~p[1];
		u.panic.right  = ~p[0];
		u.panic.fire_a = ~p[4];
		return u;
	endfunction

	function automatic cosmic_pkg::player_port_u alien_port(input logic [5:0] p);
		cosmic_pkg::player_port_u u;
		u.alien.unused = 5'h1f;
		u.alien.left   = ~p[1];
		u.alien.right  = ~p[0];
		u.alien.fire_a = ~p[4];
		return u;
	endfunction

	// Top two bits carry bonus DIPs on player 1
	function automatic logic [7:0] magspot_port(input logic [5:0] p, input logic [1:0] top);
		return {top, ~p[0], 3'b111, ~p[1], 1'b1};
	endfunction

	// Four-way stick, diagonals decode to their own codes
	function automatic logic [7:0] nml_port(input logic [5:0] p);
		if (p[4])             return 8'hff;
		else if (p[3] && p[1]) return 8'hfe;
		else if (p[2] && p[1]) return 8'hfb;
		else if (p[2] && p[0]) return 8'hef;
		else if (p[3] && p[0]) return 8'hbf;
		else                   return {~p[3], 1'b1, ~p[0], 1'b1, ~p[2], 1'b1, ~p[1], 1'b1};
	endfunction

	logic [7:0] magspot_in2;
	logic [7:0] magspot_dip;

	assign magspot_in2 = {~p1_i[4], ~p2_i[4], 5'h1f, ~vblank_i};
	assign magspot_dip = {~start1_i, ~start2_i, dip_i[5:0]};

	always_comb begin
		case (game_i)
			cosmic_pkg::GAME_PANIC: begin
				in0_o    = panic_port(p1_i);
				in1_o    = panic_port(p2_i);
				in2_o    = {1'b1, ~coin_i, 4'hf, ~start2_i, ~start1_i};
				dipsw1_o = dip_i[7:0];
			end
			cosmic_pkg::GAME_MAGSPOT, cosmic_pkg::GAME_DEVILZONE: begin
				in0_o    = magspot_port(p1_i, dip_i[15:14]);
				in1_o    = magspot_port(p2_i, 2'b11);
				in2_o    = magspot_in2;
				dipsw1_o = magspot_dip;
			end
			cosmic_pkg::GAME_NML: begin
				in0_o    = nml_port(p1_i);
				in1_o    = nml_port(p2_i);
				in2_o    = magspot_in2;
				dipsw1_o = magspot_dip;
			end
			default: begin
				in0_o    = alien_port(p1_i);
				in1_o    = alien_port(p2_i);
				// Alien polls the beam position on IN2
				in2_o    = {2'b00, vcount_i[7:2]};
				dipsw1_o = magspot_dip;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/download_router.sv
`timescale 1ns/1ps
`default_nettype none

module download_router (
	input  wire logic                             clk_sys,
	input  wire logic                             reset_i,
	input  wire logic [cosmic_pkg::GAME_W-1:0]    game_i,
	dl_bus_if.sink                                dl,
	output logic                                  rom_wr_o,
	output logic [cosmic_pkg::ROM_ADDR_W-1:0]     rom_addr_o,
	output logic                                  table_wr_o,
	output logic [7:0]                            table_addr_o,
	output logic                                  wave_wr_o,
	output logic [cosmic_pkg::DL_ADDR_W-1:0]      wave_addr_o,
	output logic [cosmic_pkg::DL_DATA_W-1:0]      data_o
);

	logic [cosmic_pkg::DL_ADDR_W-1:0] table_start;
	logic [cosmic_pkg::DL_ADDR_W-1:0] table_len;
	logic [cosmic_pkg::DL_ADDR_W-1:0] wave_start;
	logic [cosmic_pkg::DL_ADDR_W-1:0] table_rel;
	logic                             accept;
	logic                             below_table;
	logic                             below_wave;

	// Region boundaries per game
	always_comb begin
		case (game_i)
			cosmic_pkg::GAME_NML:       table_start = cosmic_pkg::TABLE_OFS_NML;
			cosmic_pkg::GAME_DEVILZONE: table_start = cosmic_pkg::TABLE_OFS_DEVILZONE;
			cosmic_pkg::GAME_ALIEN:     table_start = cosmic_pkg::TABLE_OFS_ALIEN;
			default:                    table_start = cosmic_pkg::TABLE_OFS_DEFAULT;
		endcase
	end

	assign table_len = (game_i == cosmic_pkg::GAME_NML) ?
		cosmic_pkg::TABLE_LEN_NML : cosmic_pkg::TABLE_LEN_DEFAULT;
	assign wave_start = table_start + table_len;
	assign table_rel  = dl.addr - table_start;

	// Only image index 0 holds the ROM set
	assign accept      = dl.download && (dl.index == 8'd0) && dl.wr;
	assign below_table = dl.addr < table_start;
	assign below_wave  = dl.addr < wave_start;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			rom_wr_o   <= 1'b0;
			table_wr_o <= 1'b0;
			wave_wr_o  <= 1'b0;
		end else begin
			rom_wr_o   <= accept && below_table;
			table_wr_o <= accept && !below_table && below_wave;
			wave_wr_o  <= accept && !below_wave;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_addr_o   <= dl.addr[cosmic_pkg::ROM_ADDR_W-1:0];
			table_addr_o <= table_rel[7:0];
			wave_addr_o  <= dl.addr - wave_start;
			data_o       <= dl.data;
		end
	end

endmodule

`default_nettype wire

//--- src/cosmic_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module cosmic_glue_top (
	input  wire logic                             clk_sys,
	input  wire logic                             reset_i,
	input  wire logic [cosmic_pkg::GAME_W-1:0]    game_i,
	input  wire logic [15:0]                      dip_i,
	input  wire logic [5:0]                       p1_i,
	input  wire logic [5:0]                       p2_i,
	input  wire logic                             coin_i,
	input  wire logic                             start1_i,
	input  wire logic                             start2_i,
	input  wire logic                             vblank_i,
	input  wire logic [8:0]                       vcount_i,
	input  wire logic                             dl_download_i,
	input  wire logic [7:0]                       dl_index_i,
	input  wire logic                             dl_wr_i,
	input  wire logic [cosmic_pkg::DL_ADDR_W-1:0] dl_addr_i,
	input  wire logic [cosmic_pkg::DL_DATA_W-1:0] dl_data_i,
	output logic                                  pix_ena_o,
	output logic                                  cpu_ena_o,
	output logic                                  core_reset_o,
	output logic [cosmic_pkg::PORT_W-1:0]         in0_o,
	output logic [cosmic_pkg::PORT_W-1:0]         in1_o,
	output logic [cosmic_pkg::PORT_W-1:0]         in2_o,
	output logic [cosmic_pkg::PORT_W-1:0]         dipsw1_o,
	output logic                                  rom_wr_o,
	output logic [cosmic_pkg::ROM_ADDR_W-1:0]     rom_addr_o,
	output logic                                  table_wr_o,
	output logic [7:0]                            table_addr_o,
	output logic                                  wave_wr_o,
	output logic [cosmic_pkg::DL_ADDR_W-1:0]      wave_addr_o,
	output logic [cosmic_pkg::DL_DATA_W-1:0]      data_o
);

	dl_bus_if dl ();

	// Download stream onto the internal bus
	assign dl.download = dl_download_i;
	assign dl.index    = dl_index_i;
	assign dl.wr       = dl_wr_i;
	assign dl.addr     = dl_addr_i;
	assign dl.data     = dl_data_i;

	clock_enable_gen u_clock_enable_gen (
		.clk_sys   (clk_sys),
		.reset_i   (reset_i),
		.game_i    (game_i),
		.pix_ena_o (pix_ena_o),
		.cpu_ena_o (cpu_ena_o)
	);

	reset_ctrl u_reset_ctrl (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.dl           (dl.sink),
		.core_reset_o (core_reset_o)
	);

	input_mapper u_input_mapper (
		.game_i   (game_i),
		.dip_i    (dip_i),
		.p1_i     (p1_i),
		.p2_i     (p2_i),
		.coin_i   (coin_i),
		.start1_i (start1_i),
		.start2_i (start2_i),
		.vblank_i (vblank_i),
		.vcount_i (vcount_i),
		.in0_o    (in0_o),
		.in1_o    (in1_o),
		.in2_o    (in2_o),
		.dipsw1_o (dipsw1_o)
	);

	download_router u_download_router (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.game_i       (game_i),
		.dl           (dl.sink),
		.rom_wr_o     (rom_wr_o),
		.rom_addr_o   (rom_addr_o),
		.table_wr_o   (table_wr_o),
		.table_addr_o (table_addr_o),
		.wave_wr_o    (wave_wr_o),
		.wave_addr_o  (wave_addr_o),
		.data_o       (data_o)
	);

endmodule

`default_nettype wire

//--- tb/cosmic_glue_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cosmic_glue_properties (
	input wire logic clk_sys,
	input wire logic reset_i,
	input wire logic dl_download_i,
	input wire logic pix_ena_o,
	input wire logic cpu_ena_o,
	input wire logic core_reset_o,
	input wire logic rom_wr_o,
	input wire logic table_wr_o,
	input wire logic wave_wr_o
);

	// Each accepted byte lands in one region only
	one_region_strobe: assert property (@(posedge clk_sys) disable iff (reset_i)
		$onehot0({rom_wr_o, table_wr_o, wave_wr_o}))
		else $error("more than one download write strobe is high");

	// Enables are single-cycle pulses
	cpu_ena_pulse: assert property (@(posedge clk_sys) disable iff (reset_i)
		cpu_ena_o |=> !cpu_ena_o)
		else $error("cpu_ena_o high for two cycles in a row");

	pix_ena_pulse: assert property (@(posedge clk_sys) disable iff (reset_i)
		pix_ena_o |=> !pix_ena_o)
		else $error("pix_ena_o high for two cycles in a row");

	// Core stays in reset while loading
	reset_during_download: assert property (@(posedge clk_sys) disable iff (reset_i)
		dl_download_i |=> core_reset_o)
		else $error("core_reset_o low after a download cycle");

endmodule

bind cosmic_glue_top cosmic_glue_properties u_properties (
	.clk_sys       (clk_sys),
	.reset_i       (reset_i),
	.dl_download_i (dl_download_i),
	.pix_ena_o     (pix_ena_o),
	.cpu_ena_o     (cpu_ena_o),
	.core_reset_o  (core_reset_o),
	.rom_wr_o      (rom_wr_o),
	.table_wr_o    (table_wr_o),
	.wave_wr_o     (wave_wr_o)
);

`default_nettype wire

//--- tb/tb_cosmic_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cosmic_glue;

	logic                             clk_sys;
	logic                             reset_i;
	logic [cosmic_pkg::GAME_W-1:0]    game_i;
	logic [15:0]                      dip_i;
	logic [5:0]                       p1_i;
	logic [5:0]                       p2_i;
	logic                             coin_i;
	logic                             start1_i;
	logic                             start2_i;
	logic                             vblank_i;
	logic [8:0]                       vcount_i;
	logic                             dl_download_i;
	logic [7:0]                       dl_index_i;
	logic                             dl_wr_i;
	logic [cosmic_pkg::DL_ADDR_W-1:0] dl_addr_i;
	logic [cosmic_pkg::DL_DATA_W-1:0] dl_data_i;
	logic                             pix_ena_o;
	logic                             cpu_ena_o;
	logic                             core_reset_o;
	logic [cosmic_pkg::PORT_W-1:0]    in0_o;
	logic [cosmic_pkg::PORT_W-1:0]    in1_o;
	logic [cosmic_pkg::PORT_W-1:0]    in2_o;
	logic [cosmic_pkg::PORT_W-1:0]    dipsw1_o;
	logic                             rom_wr_o;
	logic [cosmic_pkg::ROM_ADDR_W-1:0] rom_addr_o;
	logic                             table_wr_o;
	logic [7:0]                       table_addr_o;
	logic                             wave_wr_o;
	logic [cosmic_pkg::DL_ADDR_W-1:0] wave_addr_o;
	logic [cosmic_pkg::DL_DATA_W-1:0] data_o;

	logic [31:0] lfsr;
	int          errors;

	cosmic_glue_top DUT (.*);

	always #10 clk_sys = ~clk_sys;

	// Inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
		if (got !== expv) begin
			$display("error: %s = %h, expected %h", name, got, expv);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("%s: done, %0d errors", name, errors - start_errors);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Active low, so every pressed button clears its bit
	function automatic cosmic_pkg::player_port_u expected_panic(input logic [5:0] p);
		cosmic_pkg::player_port_u u;
		u = '1;
		if (p[5]) u.panic.fire_b = 1'b0;
		if (p[4]) u.panic.fire_a = 1'b0;
		if (p[3]) u.panic.up = 1'b0;
		if (p[2]) u.panic.down = 1'b0;
		if (p[1]) u.panic.left = 1'b0;
		if (p[0]) u.panic.right = 1'b0;
		return u;
	endfunction

	function automatic cosmic_pkg::player_port_u expected_alien(input logic [5:0] p);
		cosmic_pkg::player_port_u u;
		u = '1;
		if (p[4]) u.alien.fire_a = 1'b0;
		if (p[1]) u.alien.left = 1'b0;
		if (p[0]) u.alien.right = 1'b0;
		return u;
	endfunction

	// Coin on bit 6, start2 on bit 1, start1 on bit 0
	function automatic logic [7:0] expected_panic_in2(input logic coin, input logic s1,
			input logic s2);
		logic [7:0] v;
		v = 8'hff;
		if (coin) v[6] = 1'b0;
		if (s2) v[1] = 1'b0;
		if (s1) v[0] = 1'b0;
		return v;
	endfunction

	// Right on bit 5, left on bit 1
	function automatic logic [7:0] expected_magspot_player(input logic [5:0] p,
			input logic [1:0] top);
		logic [7:0] v;
		v = {top, 6'h3f};
		if (p[0]) v[5] = 1'b0;
		if (p[1]) v[1] = 1'b0;
		return v;
	endfunction

	function automatic logic [7:0] expected_magspot_in2(input logic f1, input logic f2,
			input logic vb);
		logic [7:0] v;
		v = 8'hff;
		if (f1) v[7] = 1'b0;
		if (f2) v[6] = 1'b0;
		if (vb) v[0] = 1'b0;
		return v;
	endfunction

	function automatic logic [7:0] expected_magspot_dip(input logic s1, input logic s2,
			input logic [15:0] d);
		logic [7:0] v;
		v = {2'b11, d[5:0]};
		if (s1) v[7] = 1'b0;
		if (s2) v[6] = 1'b0;
		return v;
	endfunction

	function automatic logic [24:0] table_start_for(input logic [6:0] g);
		case (g)
			cosmic_pkg::GAME_NML:       return cosmic_pkg::TABLE_OFS_NML;
			cosmic_pkg::GAME_DEVILZONE: return cosmic_pkg::TABLE_OFS_DEVILZONE;
			cosmic_pkg::GAME_ALIEN:     return cosmic_pkg::TABLE_OFS_ALIEN;
			default:                    return cosmic_pkg::TABLE_OFS_DEFAULT;
		endcase
	endfunction

	task automatic randomize_inputs();
		logic [31:0] r;
		random_bits(6, r);
		p1_i = r[5:0];
		random_bits(6, r);
		p2_i = r[5:0];
		random_bits(3, r);
		{coin_i, start1_i, start2_i} = r[2:0];
		random_bits(16, r);
		dip_i = r[15:0];
		random_bits(9, r);
		vcount_i = r[8:0];
		random_bits(1, r);
		vblank_i = r[0];
	endtask

	task automatic test_clock_enables();
		int start_errors;
		int cpu_cnt;
		int pix_cnt;
		int exp_cpu;
		start_errors = errors;
		for (int g = 1; g <= 5; g++) begin
			game_i = 7'(g);
			tick();
			tick();
			cpu_cnt = 0;
			pix_cnt = 0;
			repeat (24) begin
				tick();
				if (cpu_ena_o) cpu_cnt++;
				if (pix_ena_o) pix_cnt++;
			end
			if (game_i == cosmic_pkg::GAME_MAGSPOT || game_i == cosmic_pkg::GAME_DEVILZONE)
				exp_cpu = 24 / cosmic_pkg::DIV_FAST;
			else
				exp_cpu = 24 / cosmic_pkg::DIV_SLOW;
			check("cpu_ena_o pulse count", 32'(cpu_cnt), 32'(exp_cpu));
			check("pix_ena_o pulse count", 32'(pix_cnt), 32'd12);
		end
		report_test("clock enables", start_errors);
	endtask

	task automatic test_reset_control();
		int start_errors;
		start_errors = errors;
		// No ROM yet
		repeat (5) begin
			tick();
			check("core_reset_o", 32'(core_reset_o), 32'd1);
		end
		dl_download_i = 1'b1;
		repeat (3) tick();
		check("core_reset_o", 32'(core_reset_o), 32'd1);
		dl_download_i = 1'b0;
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd1);
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd0);
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd0);
		// Reload raises it again
		dl_download_i = 1'b1;
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd1);
		dl_download_i = 1'b0;
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd1);
		tick();
		check("core_reset_o", 32'(core_reset_o), 32'd0);
		report_test("reset control", start_errors);
	endtask

	task automatic test_panic_alien_map();
		int start_errors;
		start_errors = errors;
		repeat (8) begin
			tick();
			randomize_inputs();
			game_i = cosmic_pkg::GAME_PANIC;
			#1;
			check("in0_o", 32'(in0_o), 32'(expected_panic(p1_i)));
			check("in1_o", 32'(in1_o), 32'(expected_panic(p2_i)));
			check("in2_o", 32'(in2_o), 32'(expected_panic_in2(coin_i, start1_i, start2_i)));
			check("dipsw1_o", 32'(dipsw1_o), 32'(dip_i[7:0]));
			game_i = cosmic_pkg::GAME_ALIEN;
			#1;
			check("in0_o", 32'(in0_o), 32'(expected_alien(p1_i)));
			check("in1_o", 32'(in1_o), 32'(expected_alien(p2_i)));
			check("in2_o", 32'(in2_o), 32'(vcount_i[7:2]));
			check("dipsw1_o", 32'(dipsw1_o),
				32'(expected_magspot_dip(start1_i, start2_i, dip_i)));
		end
		report_test("panic and alien mapping", start_errors);
	endtask

	task automatic test_magspot_map();
		int start_errors;
		logic [31:0] r;
		start_errors = errors;
		repeat (8) begin
			tick();
			randomize_inputs();
			random_bits(1, r);
			game_i = r[0] ? cosmic_pkg::GAME_MAGSPOT : cosmic_pkg::GAME_DEVILZONE;
			#1;
			check("in0_o", 32'(in0_o), 32'(expected_magspot_player(p1_i, dip_i[15:14])));
			check("in1_o", 32'(in1_o), 32'(expected_magspot_player(p2_i, 2'b11)));
			check("in2_o", 32'(in2_o),
				32'(expected_magspot_in2(p1_i[4], p2_i[4], vblank_i)));
			check("dipsw1_o", 32'(dipsw1_o),
				32'(expected_magspot_dip(start1_i, start2_i, dip_i)));
		end
		report_test("magspot mapping", start_errors);
	endtask

	task automatic test_nml_map();
		int start_errors;
		logic [13:0] stick [10];
		start_errors = errors;
		// Stick bits then expected port byte
		stick = '{{6'b010000, 8'hff}, {6'b011010, 8'hff}, {6'b001010, 8'hfe},
			{6'b000110, 8'hfb}, {6'b000101, 8'hef}, {6'b001001, 8'hbf},
			{6'b001000, 8'h7f}, {6'b000001, 8'hdf}, {6'b000100, 8'hf7},
			{6'b000010, 8'hfd}};
		for (int i = 0; i < 10; i++) begin
			tick();
			game_i = cosmic_pkg::GAME_NML;
			p1_i = stick[i][13:8];
			p2_i = stick[(i + 1) % 10][13:8];
			#1;
			check("in0_o", 32'(in0_o), 32'(stick[i][7:0]));
			check("in1_o", 32'(in1_o), 32'(stick[(i + 1) % 10][7:0]));
			check("in2_o", 32'(in2_o),
				32'(expected_magspot_in2(p1_i[4], p2_i[4], vblank_i)));
		end
		report_test("nml mapping", start_errors);
	endtask

	// kind 0 ROM, 1 table, 2 wave, 3 no write expected
	task automatic write_and_check(input logic [24:0] addr, input logic [7:0] idx,
			input int kind, input logic [24:0] rebased);
		logic [31:0] r;
		random_bits(8, r);
		dl_index_i = idx;
		dl_addr_i  = addr;
		dl_data_i  = r[7:0];
		dl_wr_i    = 1'b1;
		tick();
		dl_wr_i = 1'b0;
		check("rom_wr_o", 32'(rom_wr_o), 32'(kind == 0));
		check("table_wr_o", 32'(table_wr_o), 32'(kind == 1));
		check("wave_wr_o", 32'(wave_wr_o), 32'(kind == 2));
		if (kind == 0)
			check("rom_addr_o", 32'(rom_addr_o), 32'(rebased[15:0]));
		if (kind == 1)
			check("table_addr_o", 32'(table_addr_o), 32'(rebased[7:0]));
		if (kind == 2)
			check("wave_addr_o", 32'(wave_addr_o), 32'(rebased));
		if (kind < 3)
			check("data_o", 32'(data_o), 32'(r[7:0]));
	endtask

	task automatic test_download_routing();
		int start_errors;
		logic [24:0] ts;
		logic [24:0] len;
		logic [24:0] ws;
		start_errors = errors;
		for (int g = 1; g <= 5; g++) begin
			tick();
			game_i = 7'(g);
			dl_download_i = 1'b1;
			ts  = table_start_for(game_i);
			len = (game_i == cosmic_pkg::GAME_NML) ? cosmic_pkg::TABLE_LEN_NML :
				cosmic_pkg::TABLE_LEN_DEFAULT;
			ws  = ts + len;
			write_and_check(ts - 25'd1, 8'd0, 0, ts - 25'd1);
			write_and_check(ts, 8'd0, 1, 25'd0);
			write_and_check(ws - 25'd1, 8'd0, 1, len - 25'd1);
			write_and_check(ws, 8'd0, 2, 25'd0);
			write_and_check(ts, 8'd3, 3, 25'd0);
		end
		dl_download_i = 1'b0;
		report_test("download routing", start_errors);
	endtask

	initial begin
		clk_sys       = 1'b0;
		reset_i       = 1'b1;
		game_i        = cosmic_pkg::GAME_PANIC;
		dip_i         = '0;
		p1_i          = '0;
		p2_i          = '0;
		coin_i        = 1'b0;
		start1_i      = 1'b0;
		start2_i      = 1'b0;
		vblank_i      = 1'b0;
		vcount_i      = '0;
		dl_download_i = 1'b0;
		dl_index_i    = '0;
		dl_wr_i       = 1'b0;
		dl_addr_i     = '0;
		dl_data_i     = '0;
		lfsr          = 32'h8ea4d412;
		errors        = 0;
		repeat (2) tick();
		reset_i = 1'b0;

		test_clock_enables();
		test_reset_control();
		test_panic_alien_map();
		test_magspot_map();
		test_nml_map();
		test_download_routing();

		$display("tests run: 6, errors: %0d", errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
src/cosmic_pkg.sv
src/dl_bus_if.sv
src/clock_enable_gen.sv
src/reset_ctrl.sv
src/input_mapper.sv
src/download_router.sv
src/cosmic_glue_top.sv
tb/cosmic_glue_properties.sv
tb/tb_cosmic_glue.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
	--top-module tb_cosmic_glue -o tb_cosmic_glue

./obj_dir/tb_cosmic_glue > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	exit 1
fi
exit 0
